// ==== blk_mem.sv ====
// Contents are undefined after power-up; a read in the same cycle as a write returns old data
`timescale 1ns/100ps

module blk_mem #(
  parameter int MEM_BLOCKS = 64
) (
  input  logic                             clk,
  input  logic                             mem_en,
  input  logic                             mem_we,
  input  logic [$clog2(MEM_BLOCKS)-1:0]    mem_index,
  input  logic [lsu_pkg::BLOCK_BYTES-1:0]  mem_strb,
  input  lsu_pkg::blk_u                    mem_wdata,
  output lsu_pkg::blk_u                    mem_rdata
);

  lsu_pkg::blk_u mem [MEM_BLOCKS];

  // Byte-strobed write
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      for (int i = 0; i < lsu_pkg::BLOCK_BYTES; i++) begin
        if (mem_strb[i])
          mem[mem_index].bytes[i] <= mem_wdata.bytes[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_en)
      mem_rdata <= mem[mem_index];  // One-cycle read
  end

endmodule

// ==== lsu_decode.sv ====
// Halfword and word accesses must be naturally aligned; misaligned ones only trip an assertion
`timescale 1ns/100ps

module lsu_decode (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             q_valid,
  input  lsu_pkg::lsu_cmd_e                q_cmd,
  input  logic [lsu_pkg::XLEN-1:0]         q_base,
  input  logic [11:0]                      q_offset,
  input  logic [lsu_pkg::XLEN-1:0]         q_wdata,
  input  logic [lsu_pkg::TAG_BITS-1:0]     q_tag,
  input  logic                             dec_take,
  output logic                             q_pop,
  output logic                             dec_valid,
  output logic [lsu_pkg::XLEN-1:0]         dec_addr,
  output lsu_pkg::lsu_size_e               dec_size,
  output logic                             dec_signed,
  output logic                             dec_store,
  output logic [lsu_pkg::BLOCK_BYTES-1:0]  dec_strb,
  output lsu_pkg::blk_u                    dec_wdata,
  output logic [lsu_pkg::TAG_BITS-1:0]     dec_tag
);

  logic [lsu_pkg::XLEN-1:0]        eff_addr;
  logic [lsu_pkg::OFFSET_BITS-1:0] off;
  lsu_pkg::lsu_size_e              size;
  logic [lsu_pkg::BLOCK_BYTES-1:0] strb;
  lsu_pkg::blk_u                   wdata_rep;

  assign q_pop    = q_valid && (!dec_valid || dec_take);
  assign eff_addr = q_base + {{(lsu_pkg::XLEN - 12){q_offset[11]}}, q_offset};  // Wraps mod 2^32
  assign off      = eff_addr[lsu_pkg::OFFSET_BITS-1:0];

  always_comb begin
    case (q_cmd)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = lsu_pkg::SZ_B;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = lsu_pkg::SZ_H;
      default: size = lsu_pkg::SZ_W;
    endcase
  end

  always_comb begin
    strb = '0;
    wdata_rep.words = {(lsu_pkg::BLOCK_BITS / lsu_pkg::XLEN){q_wdata}};
    case (size)
      lsu_pkg::SZ_B: begin
        strb[off] = 1'b1;
        wdata_rep.bytes = {lsu_pkg::BLOCK_BYTES{q_wdata[7:0]}};
      end
      lsu_pkg::SZ_H: begin
        strb[{off[lsu_pkg::OFFSET_BITS-1:1], 1'b0} +: 2] = 2'b11;
        wdata_rep.words = {(lsu_pkg::BLOCK_BITS / 16){q_wdata[15:0]}};
      end
      default: strb[{off[lsu_pkg::OFFSET_BITS-1:2], 2'b00} +: 4] = 4'hf;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      dec_valid <= 1'b0;
    else if (q_pop)
      dec_valid <= 1'b1;
    else if (dec_take)
      dec_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      dec_addr   <= eff_addr;
      dec_size   <= size;
      dec_signed <= q_cmd inside {lsu_pkg::LB, lsu_pkg::LH};
      dec_store  <= q_cmd inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
      dec_strb   <= strb;
      dec_wdata  <= wdata_rep;
      dec_tag    <= q_tag;
    end
  end

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    dec_valid |-> (dec_size == lsu_pkg::SZ_B) ||
                  (dec_size == lsu_pkg::SZ_H && !dec_addr[0]) ||
                  (dec_size == lsu_pkg::SZ_W && dec_addr[1:0] == 2'b00))
    else $error("lsu_decode: misaligned access to %h", dec_addr);

endmodule

// ==== lsu_exec.sv ====
// Only the block index bits modulo MEM_BLOCKS reach memory; higher address bits alias
`timescale 1ns/100ps

module lsu_exec #(
  parameter int MEM_BLOCKS = 64
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               dec_valid,
  input  logic [lsu_pkg::XLEN-1:0]           dec_addr,
  input  lsu_pkg::lsu_size_e                 dec_size,
  input  logic                               dec_signed,
  input  logic                               dec_store,
  input  logic [lsu_pkg::BLOCK_BYTES-1:0]    dec_strb,
  input  lsu_pkg::blk_u                      dec_wdata,
  input  logic [lsu_pkg::TAG_BITS-1:0]       dec_tag,
  input  logic                               slot_free,
  output logic                               dec_take,
  output logic                               mem_en,
  output logic                               mem_we,
  output logic [$clog2(MEM_BLOCKS)-1:0]      mem_index,
  output logic [lsu_pkg::BLOCK_BYTES-1:0]    mem_strb,
  output lsu_pkg::blk_u                      mem_wdata,
  output logic                               iss_valid,
  output logic [lsu_pkg::TAG_BITS-1:0]       iss_tag,
  output logic                               iss_store,
  output lsu_pkg::lsu_size_e                 iss_size,
  output logic                               iss_signed,
  output logic [lsu_pkg::OFFSET_BITS-1:0]    iss_offset
);

  localparam int IDX_W = $clog2(MEM_BLOCKS);

  logic [lsu_pkg::XLEN-lsu_pkg::OFFSET_BITS-1:0] blk_num;

  // Issue only while the result stage has room for another completion
  assign dec_take = dec_valid && slot_free;
  assign blk_num  = dec_addr[lsu_pkg::XLEN-1:lsu_pkg::OFFSET_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_en    <= 1'b0;
      mem_we    <= 1'b0;
      iss_valid <= 1'b0;
    end else begin
      mem_en    <= dec_take;
      mem_we    <= dec_take && dec_store;
      iss_valid <= dec_take;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_take) begin
      mem_index  <= IDX_W'(blk_num % MEM_BLOCKS);
      mem_strb   <= dec_strb;
      mem_wdata  <= dec_wdata;
      iss_tag    <= dec_tag;
      iss_store  <= dec_store;
      iss_size   <= dec_size;
      iss_signed <= dec_signed;
      iss_offset <= dec_addr[lsu_pkg::OFFSET_BITS-1:0];  // Byte lane for load extraction
    end
  end

  a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
    mem_we |-> mem_en && mem_strb != '0)
    else $error("lsu_exec: write without enable or byte strobes");

endmodule

// ==== lsu_pkg.sv ====
// Widths are fixed here; the block is 128 bits and blk_u depends on that, so keep them in step
package lsu_pkg;

  localparam int XLEN = 32;
  localparam int BLOCK_BITS = 128;
  localparam int BLOCK_BYTES = BLOCK_BITS / 8;
  localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);  // Byte offset inside a block
  localparam int TAG_BITS = 4;

  // Dispatcher command encoding
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LH  = 4'd1,
    LW  = 4'd2,
    LBU = 4'd3,
    LHU = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_cmd_e;

  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2
  } lsu_size_e;

  // One memory block seen as words or as bytes
  typedef union packed {
    logic [BLOCK_BITS/XLEN-1:0][XLEN-1:0] words;
    logic [BLOCK_BYTES-1:0][7:0] bytes;
  } blk_u;

endpackage

// ==== lsu_req_queue.sv ====
// Needs QUEUE_DEPTH >= 2; the dispatcher must hold a credit per push, overflow is not handled
`timescale 1ns/100ps

module lsu_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid,
  input  lsu_pkg::lsu_cmd_e             req_cmd,
  input  logic [lsu_pkg::XLEN-1:0]      req_base,
  input  logic [11:0]                   req_offset,
  input  logic [lsu_pkg::XLEN-1:0]      req_wdata,
  input  logic [lsu_pkg::TAG_BITS-1:0]  req_tag,
  input  logic                          q_pop,
  output logic                          q_valid,
  output lsu_pkg::lsu_cmd_e             q_cmd,
  output logic [lsu_pkg::XLEN-1:0]      q_base,
  output logic [11:0]                   q_offset,
  output logic [lsu_pkg::XLEN-1:0]      q_wdata,
  output logic [lsu_pkg::TAG_BITS-1:0]  q_tag,
  output logic                          req_credit
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  lsu_pkg::lsu_cmd_e              cmd_mem    [QUEUE_DEPTH];
  logic [lsu_pkg::XLEN-1:0]       base_mem   [QUEUE_DEPTH];
  logic [11:0]                    offset_mem [QUEUE_DEPTH];
  logic [lsu_pkg::XLEN-1:0]       wdata_mem  [QUEUE_DEPTH];
  logic [lsu_pkg::TAG_BITS-1:0]   tag_mem    [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      cmd_mem[wr_ptr]    <= req_cmd;
      base_mem[wr_ptr]   <= req_base;
      offset_mem[wr_ptr] <= req_offset;
      wdata_mem[wr_ptr]  <= req_wdata;
      tag_mem[wr_ptr]    <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid)
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (q_pop)
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count      <= count + CNT_W'(req_valid) - CNT_W'(q_pop);
      req_credit <= q_pop;  // One credit back per entry popped
    end
  end

  assign q_valid  = (count != '0);
  assign q_cmd    = cmd_mem[rd_ptr];
  assign q_base   = base_mem[rd_ptr];
  assign q_offset = offset_mem[rd_ptr];
  assign q_wdata  = wdata_mem[rd_ptr];
  assign q_tag    = tag_mem[rd_ptr];

  // Dispatcher credit accounting keeps pushes off a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> count < CNT_W'(QUEUE_DEPTH))
    else $error("lsu_req_queue: push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) q_pop |-> q_valid)
    else $error("lsu_req_queue: pop while empty");

endmodule

// ==== lsu_result.sv ====
// WB_CREDITS must match the write-back buffer; wb_credit pulses beyond it trip an assertion
`timescale 1ns/100ps

module lsu_result #(
  parameter int WB_CREDITS = 2
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             iss_valid,
  input  logic [lsu_pkg::TAG_BITS-1:0]     iss_tag,
  input  logic                             iss_store,
  input  lsu_pkg::lsu_size_e               iss_size,
  input  logic                             iss_signed,
  input  logic [lsu_pkg::OFFSET_BITS-1:0]  iss_offset,
  input  lsu_pkg::blk_u                    mem_rdata,
  input  logic                             wb_credit,
  output logic                             slot_free,
  output logic                             wb_valid,
  output logic [lsu_pkg::TAG_BITS-1:0]     wb_tag,
  output logic [lsu_pkg::XLEN-1:0]         wb_result,
  output logic                             wb_store
);

  localparam int CNT_W = $clog2(WB_CREDITS + 1) + 1;
  localparam int OB = lsu_pkg::OFFSET_BITS;

  logic                          s1_valid, s1_store, s1_signed;
  logic [lsu_pkg::TAG_BITS-1:0]  s1_tag;
  lsu_pkg::lsu_size_e            s1_size;
  logic [OB-1:0]                 s1_offset;
  logic [7:0]                    ld_byte;
  logic [15:0]                   ld_half;
  logic [lsu_pkg::XLEN-1:0]      ld_data;
  logic [CNT_W-1:0]              credit_cnt, inflight;

  // Side-band lined up with mem_rdata
  always_ff @(posedge clk) begin
    if (rst)
      s1_valid <= 1'b0;
    else
      s1_valid <= iss_valid;
  end

  always_ff @(posedge clk) begin
    s1_tag    <= iss_tag;
    s1_store  <= iss_store;
    s1_size   <= iss_size;
    s1_signed <= iss_signed;
    s1_offset <= iss_offset;
  end

  assign ld_byte = mem_rdata.bytes[s1_offset];
  assign ld_half = {mem_rdata.bytes[{s1_offset[OB-1:1], 1'b1}],
                    mem_rdata.bytes[{s1_offset[OB-1:1], 1'b0}]};

  always_comb begin
    case (s1_size)
      lsu_pkg::SZ_B: ld_data = {{(lsu_pkg::XLEN - 8){s1_signed & ld_byte[7]}}, ld_byte};
      lsu_pkg::SZ_H: ld_data = {{(lsu_pkg::XLEN - 16){s1_signed & ld_half[15]}}, ld_half};
      default: ld_data = mem_rdata.words[s1_offset[OB-1:2]];
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      wb_valid <= 1'b0;
    else
      wb_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      wb_tag    <= s1_tag;
      wb_store  <= s1_store;
      wb_result <= s1_store ? '0 : ld_data;
    end
  end

  // A credit is spent when the completion is registered
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CNT_W'(WB_CREDITS);
      inflight   <= '0;
    end else begin
      credit_cnt <= credit_cnt + CNT_W'(wb_credit) - CNT_W'(s1_valid);
      inflight   <= inflight + CNT_W'(iss_valid) - CNT_W'(s1_valid);
    end
  end

  assign slot_free = (inflight + CNT_W'(iss_valid)) < credit_cnt;  // Counts this cycle's issue too

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CNT_W'(WB_CREDITS))
    else $error("lsu_result: more write-back credits returned than granted");

endmodule

// ==== lsu_sys.f ====
lsu_pkg.sv
lsu_req_queue.sv
lsu_decode.sv
lsu_exec.sv
blk_mem.sv
lsu_result.sv
lsu_sys.sv
tb_lsu_sys.sv

// ==== lsu_sys.sv ====
// One outstanding dispatcher credit per queue entry; no caches, atomics or exceptions
`timescale 1ns/100ps

module lsu_sys #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_BLOCKS  = 64,
  parameter int WB_CREDITS  = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid,
  input  lsu_pkg::lsu_cmd_e             req_cmd,
  input  logic [lsu_pkg::XLEN-1:0]      req_base,
  input  logic [11:0]                   req_offset,
  input  logic [lsu_pkg::XLEN-1:0]      req_wdata,
  input  logic [lsu_pkg::TAG_BITS-1:0]  req_tag,
  input  logic                          wb_credit,
  output logic                          req_credit,
  output logic                          wb_valid,
  output logic [lsu_pkg::TAG_BITS-1:0]  wb_tag,
  output logic [lsu_pkg::XLEN-1:0]      wb_result,
  output logic                          wb_store
);

  // Queue to decode
  logic                             q_valid, q_pop;
  lsu_pkg::lsu_cmd_e                q_cmd;
  logic [lsu_pkg::XLEN-1:0]         q_base, q_wdata;
  logic [11:0]                      q_offset;
  logic [lsu_pkg::TAG_BITS-1:0]     q_tag;

  // Decode to exec
  logic                             dec_valid, dec_take, dec_signed, dec_store;
  logic [lsu_pkg::XLEN-1:0]         dec_addr;
  lsu_pkg::lsu_size_e               dec_size;
  logic [lsu_pkg::BLOCK_BYTES-1:0]  dec_strb;
  lsu_pkg::blk_u                    dec_wdata;
  logic [lsu_pkg::TAG_BITS-1:0]     dec_tag;

  // Memory port and issue side-band
  logic                             mem_en, mem_we, slot_free;
  logic [$clog2(MEM_BLOCKS)-1:0]    mem_index;
  logic [lsu_pkg::BLOCK_BYTES-1:0]  mem_strb;
  lsu_pkg::blk_u                    mem_wdata, mem_rdata;
  logic                             iss_valid, iss_store, iss_signed;
  logic [lsu_pkg::TAG_BITS-1:0]     iss_tag;
  lsu_pkg::lsu_size_e               iss_size;
  logic [lsu_pkg::OFFSET_BITS-1:0]  iss_offset;

  lsu_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_lsu_req_queue (.*);

  lsu_decode i_lsu_decode (.*);

  lsu_exec #(.MEM_BLOCKS(MEM_BLOCKS)) i_lsu_exec (.*);

  blk_mem #(.MEM_BLOCKS(MEM_BLOCKS)) i_blk_mem (.*);

  lsu_result #(.WB_CREDITS(WB_CREDITS)) i_lsu_result (.*);

endmodule

// ==== tb_lsu_sys.sv ====
// Self-checking testbench for the default lsu_sys parameters; all stimulus is aligned
`timescale 1ns/100ps

module tb_lsu_sys;

  localparam int QUEUE_DEPTH = 4;
  localparam int MEM_BLOCKS  = 64;
  localparam int WB_CREDITS  = 2;
  localparam int NUM_STORES  = 12;
  localparam int NUM_ENTRIES = 2 * NUM_STORES;
  localparam int MAX_CYCLES  = 40 * NUM_ENTRIES + 100;
  localparam int HOLD_START  = 20;  // Write-back credits withheld in this window
  localparam int HOLD_END    = 50;

  logic clk, rst, req_valid, wb_credit, req_credit, wb_valid, wb_store;
  lsu_pkg::lsu_cmd_e req_cmd;
  logic [lsu_pkg::XLEN-1:0] req_base, req_wdata, wb_result;
  logic [11:0] req_offset;
  logic [lsu_pkg::TAG_BITS-1:0] req_tag, wb_tag;

  lsu_pkg::lsu_cmd_e tab_cmd [NUM_ENTRIES];
  logic [31:0] tab_base [NUM_ENTRIES];
  logic [11:0] tab_off [NUM_ENTRIES];
  logic [31:0] tab_data [NUM_ENTRIES];
  logic [7:0] model [MEM_BLOCKS * 16];  // Byte image of blk_mem
  logic [lsu_pkg::TAG_BITS-1:0] exp_tag [$];
  logic [lsu_pkg::XLEN-1:0] exp_result [$];
  logic exp_store [$];

  logic [31:0] tab_seed = 32'd1114;
  logic [31:0] wb_seed = 32'd1114;
  int value_errs = 0;
  int other_errs = 0;
  int disp_credits = QUEUE_DEPTH;
  int credit_pulses = 0;
  int sent = 0;
  int done_cnt = 0;
  int owed = 0;
  int wb_seen = 0;
  int wb_returned = 0;
  int cycles = 0;

  lsu_sys #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_BLOCKS(MEM_BLOCKS), .WB_CREDITS(WB_CREDITS))
    i_lsu_sys (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Same block aliasing as the DUT
  function automatic int model_index(input logic [31:0] addr);
    return int'((addr >> 4) % MEM_BLOCKS) * 16 + int'(addr[3:0]);
  endfunction

  task automatic check_result(input logic [lsu_pkg::XLEN-1:0] got,
                              input logic [lsu_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t: wb_result %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_tag(input logic [lsu_pkg::TAG_BITS-1:0] got,
                           input logic [lsu_pkg::TAG_BITS-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t: wb_tag %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_store(input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t: wb_store %b, expected %b", $time, got, exp);
    end
  endtask

  // Stores go first and each gets a later load of the same bytes
  task automatic build_table();
    logic [31:0] addr, data;
    logic [11:0] st_off, ld_off;
    for (int i = 0; i < NUM_STORES; i++) begin
      tab_seed = lcg_step(tab_seed);
      addr = tab_seed;
      tab_seed = lcg_step(tab_seed);
      data = (i % 4 < 2) ? (tab_seed | 32'h8080_8080) : (tab_seed & 32'h7f7f_7f7f);
      st_off = (i % 2) ? 12'hfd0 : 12'h010;  // -48 or +16
      ld_off = (i % 2) ? 12'h000 : 12'hfc0;  // 0 or -64
      case (i % 3)
        0: begin
          tab_cmd[i] = lsu_pkg::SB;
          tab_cmd[NUM_STORES + i] = (i % 2) ? lsu_pkg::LBU : lsu_pkg::LB;
        end
        1: begin
          addr[0] = 1'b0;
          tab_cmd[i] = lsu_pkg::SH;
          tab_cmd[NUM_STORES + i] = (i % 2) ? lsu_pkg::LHU : lsu_pkg::LH;
        end
        default: begin
          addr[1:0] = 2'b00;
          tab_cmd[i] = lsu_pkg::SW;
          tab_cmd[NUM_STORES + i] = lsu_pkg::LW;
        end
      endcase
      tab_base[i] = addr - {{20{st_off[11]}}, st_off};
      tab_off[i] = st_off;
      tab_data[i] = data;
      tab_base[NUM_STORES + i] = addr - {{20{ld_off[11]}}, ld_off};
      tab_off[NUM_STORES + i] = ld_off;
      tab_data[NUM_STORES + i] = '0;
    end
  endtask

  task automatic apply_entry(input int k);
    logic [31:0] eff, val;
    logic is_store;
    int a;
    eff = tab_base[k] + {{20{tab_off[k][11]}}, tab_off[k]};
    a = model_index(eff);
    val = '0;
    is_store = tab_cmd[k] inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    req_valid  <= 1'b1;
    req_cmd    <= tab_cmd[k];
    req_base   <= tab_base[k];
    req_offset <= tab_off[k];
    req_wdata  <= tab_data[k];
    req_tag    <= lsu_pkg::TAG_BITS'(k);
    case (tab_cmd[k])
      lsu_pkg::SB: model[a] = tab_data[k][7:0];
      lsu_pkg::SH: {model[a + 1], model[a]} = tab_data[k][15:0];
      lsu_pkg::SW: {model[a + 3], model[a + 2], model[a + 1], model[a]} = tab_data[k];
      lsu_pkg::LB: val = {{24{model[a][7]}}, model[a]};
      lsu_pkg::LBU: val = {24'h0, model[a]};
      lsu_pkg::LH: val = {{16{model[a + 1][7]}}, model[a + 1], model[a]};
      lsu_pkg::LHU: val = {16'h0, model[a + 1], model[a]};
      default: val = {model[a + 3], model[a + 2], model[a + 1], model[a]};
    endcase
    exp_tag.push_back(lsu_pkg::TAG_BITS'(k));
    exp_result.push_back(val);
    exp_store.push_back(is_store);
  endtask

  task automatic collect_credit();
    if (req_credit) begin
      credit_pulses++;
      disp_credits++;
      if (disp_credits > QUEUE_DEPTH) begin
        other_errs++;
        $display("More dispatcher credits returned than queue entries at %0t", $time);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    req_valid = 1'b0;
    req_cmd = lsu_pkg::LB;
    req_base = '0;
    req_offset = '0;
    req_wdata = '0;
    req_tag = '0;
    wb_credit = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (sent < NUM_ENTRIES) begin
      @(posedge clk);
      collect_credit();
      req_valid <= 1'b0;
      tab_seed = lcg_step(tab_seed);
      if (disp_credits > 0 && tab_seed[17:16] != 2'b00) begin  // Random gaps between sends
        disp_credits--;
        apply_entry(sent);
        sent++;
      end
    end
    @(posedge clk);
    collect_credit();
    req_valid <= 1'b0;
    while (done_cnt < NUM_ENTRIES) begin
      @(posedge clk);
      collect_credit();
    end
    repeat (3) begin
      @(posedge clk);
      collect_credit();
    end
    if (credit_pulses != NUM_ENTRIES) begin
      other_errs++;
      $display("Got %0d req_credit pulses for %0d commands", credit_pulses, NUM_ENTRIES);
    end
    $display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Write-back side that returns one credit per completion
  always @(posedge clk) begin
    if (rst) begin
      wb_credit <= 1'b0;
    end else begin
      if (wb_valid) begin
        if (exp_tag.size() == 0) begin
          other_errs++;
          $display("Completion with tag %h arrived with nothing outstanding at %0t",
                   wb_tag, $time);
        end else begin
          check_tag(wb_tag, exp_tag.pop_front());
          check_result(wb_result, exp_result.pop_front());
          check_store(wb_store, exp_store.pop_front());
        end
        done_cnt <= done_cnt + 1;
        owed++;
        wb_seen++;
      end
      if (wb_seen - wb_returned > WB_CREDITS) begin
        other_errs++;
        $display("Write-back completions exceed granted credits at %0t", $time);
      end
      wb_seed = lcg_step(wb_seed);
      if (owed > 0 && !(cycles >= HOLD_START && cycles < HOLD_END) &&
          wb_seed[17:16] != 2'b00) begin
        wb_credit <= 1'b1;
        owed--;
        wb_returned++;
      end else begin
        wb_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d completions seen",
               cycles, done_cnt, NUM_ENTRIES);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule
